// ==== hdl/fifo_geom_pkg.sv ====
/* FIFO geometry: address and pointer widths, depth,
   synchronizer default, pointer type and Gray encoding */

package fifo_geom_pkg;

  // --------------------------------------------------------------------------
  // Storage geometry
  // --------------------------------------------------------------------------

  // Address width, 8 entries by default
  parameter int ADDR_W = 3;

  // Number of storage words
  parameter int DEPTH = 1 << ADDR_W;

  // Pointer carries one wrap bit above the address
  parameter int PTR_W = ADDR_W + 1;

  // --------------------------------------------------------------------------
  // Clock crossing
  // --------------------------------------------------------------------------

  // Flops per pointer synchronizer
  parameter int SYNC_STAGES_DEF = 2;

  // Binary or Gray pointer, wrap bit in the MSB
  typedef logic [PTR_W-1:0] ptr_t;

  // Binary to Gray, one bit changes per increment
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

// ==== hdl/fifo_data_pkg.sv ====
/* Payload word and the write and read port bundles */

package fifo_data_pkg;

  // Field widths of the payload
  parameter int TAG_W   = 4;
  parameter int VALUE_W = 12;

  // Word carried through the FIFO, 16 bits
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [VALUE_W-1:0] value;
  } payload_t;

  // --------------------------------------------------------------------------
  // Port bundles
  // --------------------------------------------------------------------------

  // Write side, driven by the producer
  // Push only counts while full is low
  typedef struct packed {
    logic     push;
    payload_t data;
  } wr_port_t;

  // Read side, driven by the FIFO
  // data is only meaningful while rd_valid is high
  typedef struct packed {
    logic     rd_valid;
    payload_t data;
  } rd_port_t;

endpackage

// ==== hdl/gray_ptr_sync.sv ====
/* Flop chain moving a Gray pointer into another clock domain */

`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int SYNC_STAGES = fifo_geom_pkg::SYNC_STAGES_DEF,
  parameter int PTR_W       = fifo_geom_pkg::PTR_W
) (
  // Destination clock
  input  logic                clk,
  input  logic                arstn,
  // Gray pointer from the source domain
  input  fifo_geom_pkg::ptr_t ptr_in,
  // Same pointer, SYNC_STAGES edges later
  output fifo_geom_pkg::ptr_t ptr_out
);

  // --------------------------------------------------------------------------
  // Synchronizer chain
  // --------------------------------------------------------------------------

  // Stage 0 samples the foreign pointer
  // Gray coding keeps every sample either old or new value
  logic [PTR_W-1:0] stage_q [SYNC_STAGES];

  always_ff @(posedge clk or negedge arstn)
  begin
    if (!arstn)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= ptr_in;
      // Shift towards the output
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Last stage is the settled copy
  assign ptr_out = stage_q[SYNC_STAGES-1];

endmodule

// ==== hdl/wr_ptr_ctrl.sv ====
/* Write-domain pointer logic: binary and Gray write pointer,
   full flag and RAM write enable */

`timescale 1ns/1ps

module wr_ptr_ctrl #(
  parameter int ADDR_W = fifo_geom_pkg::ADDR_W
) (
  input  logic                clk,
  input  logic                arstn,
  // Producer request
  input  logic                push,
  // Read pointer seen in the write domain
  input  fifo_geom_pkg::ptr_t rd_gray_sync,
  output logic                full,
  // RAM write port
  output logic                wr_en,
  output logic [ADDR_W-1:0]   wr_addr,
  // Gray pointer towards the read domain
  output fifo_geom_pkg::ptr_t wr_gray
);

  import fifo_geom_pkg::*;

  // Top two bits flipped means one lap ahead, same slot
  localparam ptr_t FULL_MASK = ptr_t'(2'b11) << (ADDR_W - 1);

  ptr_t wr_bin_q;
  ptr_t wr_bin_next;
  ptr_t wr_gray_q;
  ptr_t wr_gray_next;
  logic full_q;

  // --------------------------------------------------------------------------
  // Next pointer
  // --------------------------------------------------------------------------

  // Accept only while not full, otherwise the word is dropped
  assign wr_en = push & ~full_q;

  assign wr_bin_next  = wr_bin_q + ptr_t'(wr_en);
  assign wr_gray_next = bin2gray(wr_bin_next);

  // --------------------------------------------------------------------------
  // Pointer and flag registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arstn)
  begin
    if (!arstn)
    begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
      full_q    <= 1'b0;
    end
    else
    begin
      wr_bin_q  <= wr_bin_next;
      wr_gray_q <= wr_gray_next;
      // Stale read pointer only keeps full high longer
      full_q    <= (wr_gray_next == (rd_gray_sync ^ FULL_MASK));
    end
  end

  // Outputs
  assign full    = full_q;
  assign wr_addr = wr_bin_q[ADDR_W-1:0];
  assign wr_gray = wr_gray_q;

endmodule

// ==== hdl/rd_ptr_ctrl.sv ====
/* Read-domain pointer logic: binary and Gray read pointer,
   empty flag, RAM read enable and read-data valid */

`timescale 1ns/1ps

module rd_ptr_ctrl #(
  parameter int ADDR_W = fifo_geom_pkg::ADDR_W
) (
  input  logic                rd_clk,
  input  logic                arstn,
  // Consumer request
  input  logic                pop,
  // Write pointer seen in the read domain
  input  fifo_geom_pkg::ptr_t wr_gray_sync,
  output logic                empty,
  // RAM read port
  output logic                rd_en,
  output logic [ADDR_W-1:0]   rd_addr,
  // One cycle after rd_en
  output logic                rd_valid,
  // Gray pointer towards the write domain
  output fifo_geom_pkg::ptr_t rd_gray
);

  import fifo_geom_pkg::*;

  ptr_t rd_bin_q;
  ptr_t rd_bin_next;
  ptr_t rd_gray_q;
  ptr_t rd_gray_next;
  logic empty_q;
  logic rd_valid_q;

  // --------------------------------------------------------------------------
  // Next pointer
  // --------------------------------------------------------------------------

  // Pop ignored while empty
  assign rd_en = pop & ~empty_q;

  assign rd_bin_next  = rd_bin_q + ptr_t'(rd_en);
  assign rd_gray_next = bin2gray(rd_bin_next);

  // --------------------------------------------------------------------------
  // Pointer, flag and valid registers
  // --------------------------------------------------------------------------

  always_ff @(posedge rd_clk or negedge arstn)
  begin
    if (!arstn)
    begin
      rd_bin_q   <= '0;
      rd_gray_q  <= '0;
      empty_q    <= 1'b1;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      rd_bin_q   <= rd_bin_next;
      rd_gray_q  <= rd_gray_next;
      // Equal pointers incl. wrap bit, nothing left to read
      empty_q    <= (rd_gray_next == wr_gray_sync);
      // Data lands in the RAM output register on this edge
      rd_valid_q <= rd_en;
    end
  end

  // Outputs
  assign empty    = empty_q;
  assign rd_addr  = rd_bin_q[ADDR_W-1:0];
  assign rd_valid = rd_valid_q;
  assign rd_gray  = rd_gray_q;

endmodule

// ==== hdl/dual_clk_ram.sv ====
/* Two-clock storage array, write port on clk and
   registered read port on rd_clk, payload set by type parameter */

`timescale 1ns/1ps

module dual_clk_ram #(
  parameter type payload_t = fifo_data_pkg::payload_t,
  parameter int  ADDR_W    = fifo_geom_pkg::ADDR_W
) (
  // Write port
  input  logic              clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  payload_t          wr_data,
  // Read port
  input  logic              rd_clk,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output payload_t          rd_data
);

  localparam int DEPTH = 1 << ADDR_W;

  // Storage, contents undefined until written
  payload_t mem [DEPTH];
  payload_t rd_data_q;

  // Write side, word stored at the accepting edge
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read side, output held between pops
  always_ff @(posedge rd_clk)
  begin
    if (rd_en)
    begin
      rd_data_q <= mem[rd_addr];
    end
  end

  assign rd_data = rd_data_q;

endmodule

// ==== hdl/async_fifo_top.sv ====
/* Dual-clock FIFO top: pointer controllers, pointer
   synchronizers in both directions and the storage RAM */

`timescale 1ns/1ps

module async_fifo_top #(
  parameter int ADDR_W      = fifo_geom_pkg::ADDR_W,
  parameter int SYNC_STAGES = fifo_geom_pkg::SYNC_STAGES_DEF
) (
  // Write domain
  input  logic                     clk,
  // Read domain
  input  logic                     rd_clk,
  // Shared async reset
  input  logic                     arstn,
  // Producer side
  input  fifo_data_pkg::wr_port_t  wr,
  output logic                     full,
  // Consumer side
  input  logic                     pop,
  output fifo_data_pkg::rd_port_t  rd,
  output logic                     empty
);

  import fifo_geom_pkg::*;
  import fifo_data_pkg::*;

  // --------------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------------

  // Write domain
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  ptr_t              wr_gray;
  ptr_t              rd_gray_sync;

  // Read domain
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_valid;
  ptr_t              rd_gray;
  ptr_t              wr_gray_sync;
  payload_t          rd_data;

  // --------------------------------------------------------------------------
  // Write-domain control
  // --------------------------------------------------------------------------

  wr_ptr_ctrl #(
    .ADDR_W (ADDR_W)
  ) wr_ptr_ctrl_i (
    .clk          (clk),
    .arstn        (arstn),
    .push         (wr.push),
    .rd_gray_sync (rd_gray_sync),
    .full         (full),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray)
  );

  // Read pointer into the write domain
  gray_ptr_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .PTR_W       (ADDR_W + 1)
  ) rd_ptr_sync_i (
    .clk     (clk),
    .arstn   (arstn),
    .ptr_in  (rd_gray),
    .ptr_out (rd_gray_sync)
  );

  // --------------------------------------------------------------------------
  // Read-domain control
  // --------------------------------------------------------------------------

  rd_ptr_ctrl #(
    .ADDR_W (ADDR_W)
  ) rd_ptr_ctrl_i (
    .rd_clk       (rd_clk),
    .arstn        (arstn),
    .pop          (pop),
    .wr_gray_sync (wr_gray_sync),
    .empty        (empty),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_valid     (rd_valid),
    .rd_gray      (rd_gray)
  );

  // Write pointer into the read domain
  gray_ptr_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .PTR_W       (ADDR_W + 1)
  ) wr_ptr_sync_i (
    .clk     (rd_clk),
    .arstn   (arstn),
    .ptr_in  (wr_gray),
    .ptr_out (wr_gray_sync)
  );

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  dual_clk_ram #(
    .payload_t (fifo_data_pkg::payload_t),
    .ADDR_W    (ADDR_W)
  ) dual_clk_ram_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr.data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Read bundle
  assign rd = '{rd_valid: rd_valid, data: rd_data};

endmodule

// ==== sim/async_fifo_tb.sv ====
/* Dual-clock FIFO testbench: clocks, reset, operation table,
   compare tasks and a model queue of the FIFO contents */

`timescale 1ns/1ps

module async_fifo_tb;

  import fifo_geom_pkg::*;
  import fifo_data_pkg::*;

  localparam int N_OPS       = 9;
  localparam int TIMEOUT_CYC = 50;

  // Operation kinds of the stimulus table
  typedef enum int {OP_PUSH, OP_POP, OP_PUSH_FULL, OP_DRAIN, OP_MIX} op_e;

  // count words, base payload, flag level expected afterwards
  typedef struct packed {
    op_e      op;
    int       count;
    payload_t data;
    logic     exp_flag;
  } op_entry_t;

  logic     clk = 1'b0;
  logic     rd_clk = 1'b0;
  logic     arstn;
  wr_port_t wr;
  logic     full;
  logic     pop;
  rd_port_t rd;
  logic     empty;

  integer    seed;
  bit        rd_started = 1'b0;
  op_entry_t ops [N_OPS];
  payload_t  model_q [$];

  async_fifo_top #(
    .ADDR_W      (fifo_geom_pkg::ADDR_W),
    .SYNC_STAGES (fifo_geom_pkg::SYNC_STAGES_DEF)
  ) async_fifo_top_i (
    .clk    (clk),
    .rd_clk (rd_clk),
    .arstn  (arstn),
    .wr     (wr),
    .full   (full),
    .pop    (pop),
    .rd     (rd),
    .empty  (empty)
  );

  // ------------------------------------------------------------------------
  // Two 40 ns clocks with the read clock 13 ns behind
  // ------------------------------------------------------------------------

  always #20 clk = ~clk;

  always
  begin
    if (!rd_started)
    begin
      rd_started = 1'b1;
      #13;
    end
    #20 rd_clk = ~rd_clk;
  end

  // ------------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------------------

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_payload(input string name, input payload_t exp, input payload_t act);
    if (act !== exp)
    begin
      $display("** Error %s: expected tag %h value %h, actual tag %h value %h",
               name, exp.tag, exp.value, act.tag, act.value);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error %s: expected %0b, actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------------
  // Bounded waits that return 2 ns after an edge of their clock
  // ------------------------------------------------------------------------

  task automatic wait_full(input logic level, input string name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    while (full !== level)
    begin
      if (cycles == TIMEOUT_CYC)
      begin
        $display("%s: full did not reach %0b within %0d clk cycles", name, level, TIMEOUT_CYC);
        abort_run();
      end
      cycles++;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_empty(input logic level, input string name);
    int cycles;
    cycles = 0;
    @(posedge rd_clk);
    #2;
    while (empty !== level)
    begin
      if (cycles == TIMEOUT_CYC)
      begin
        $display("%s: empty did not reach %0b within %0d rd_clk cycles", name, level,
                 TIMEOUT_CYC);
        abort_run();
      end
      cycles++;
      @(posedge rd_clk);
      #2;
    end
  endtask

  // Called right after a read clock edge so no leading edge
  task automatic wait_valid(input string name);
    int cycles;
    cycles = 0;
    while (rd.rd_valid !== 1'b1)
    begin
      if (cycles == TIMEOUT_CYC)
      begin
        $display("%s: no read data within %0d rd_clk cycles after a pop", name, TIMEOUT_CYC);
        abort_run();
      end
      cycles++;
      @(posedge rd_clk);
      #2;
    end
  endtask

  // A high flag is awaited with a timeout and a low flag checked at once
  task automatic expect_full(input logic level, input string name);
    if (level)
    begin
      wait_full(1'b1, name);
    end
    else
    begin
      check_flag({name, " full"}, 1'b0, full);
    end
  endtask

  task automatic expect_empty(input logic level, input string name);
    if (level)
    begin
      wait_empty(1'b1, name);
    end
    else
    begin
      check_flag({name, " empty"}, 1'b0, empty);
    end
  endtask

  // ------------------------------------------------------------------------
  // Producer and consumer
  // ------------------------------------------------------------------------

  // Push held off while full so every push here is accepted
  task automatic push_word(input payload_t word, input string name);
    wait_full(1'b0, name);
    wr.push = 1'b1;
    wr.data = word;
    @(posedge clk);
    #2;
    wr.push = 1'b0;
    model_q.push_back(word);
  endtask

  task automatic pop_word(input string name);
    wait_empty(1'b0, name);
    pop = 1'b1;
    @(posedge rd_clk);
    #2;
    pop = 1'b0;
    wait_valid(name);
    if (model_q.size() == 0)
    begin
      $display("%s: FIFO returned a word that was never pushed", name);
      abort_run();
    end
    check_payload(name, model_q.pop_front(), rd.data);
  endtask

  function automatic payload_t rand_word();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Word k of a burst with the value stepped from the table entry
  function automatic payload_t next_word(input payload_t base, input int k);
    payload_t w;
    w = base;
    w.value = base.value + k[VALUE_W-1:0];
    return w;
  endfunction

  // ------------------------------------------------------------------------
  // Operation table
  // ------------------------------------------------------------------------

  function automatic void build_table();
    ops[0] = '{OP_PUSH,      3,  rand_word(), 1'b0};
    ops[1] = '{OP_POP,       3,  rand_word(), 1'b1};
    // Fill all 8 slots so full has to rise
    ops[2] = '{OP_PUSH,      8,  rand_word(), 1'b1};
    ops[3] = '{OP_PUSH_FULL, 1,  rand_word(), 1'b1};
    ops[4] = '{OP_DRAIN,     0,  rand_word(), 1'b1};
    ops[5] = '{OP_PUSH,      5,  rand_word(), 1'b0};
    ops[6] = '{OP_POP,       2,  rand_word(), 1'b0};
    ops[7] = '{OP_DRAIN,     0,  rand_word(), 1'b1};
    // Long interleaved run where pointers wrap several times
    ops[8] = '{OP_MIX,       40, rand_word(), 1'b1};
  endfunction

  task automatic apply_op(input int idx);
    op_entry_t e;
    string     name;
    int        p_gap;
    int        c_gap;
    e = ops[idx];
    name = $sformatf("op %0d %s", idx, e.op.name());
    case (e.op)
      OP_PUSH:
      begin
        for (int k = 0; k < e.count; k++)
        begin
          push_word(next_word(e.data, k), name);
        end
        expect_full(e.exp_flag, name);
      end
      OP_POP:
      begin
        for (int k = 0; k < e.count; k++)
        begin
          pop_word(name);
        end
        expect_empty(e.exp_flag, name);
      end
      OP_PUSH_FULL:
      begin
        @(posedge clk);
        #2;
        check_flag({name, " full before"}, e.exp_flag, full);
        // Word must be dropped and the model left alone
        wr.push = 1'b1;
        wr.data = e.data;
        @(posedge clk);
        #2;
        wr.push = 1'b0;
        check_flag({name, " full after"}, e.exp_flag, full);
      end
      OP_DRAIN:
      begin
        while (model_q.size() > 0)
        begin
          pop_word(name);
        end
        expect_empty(e.exp_flag, name);
        // Pop on an empty FIFO gives no data
        pop = 1'b1;
        @(posedge rd_clk);
        #2;
        pop = 1'b0;
        check_flag({name, " rd_valid"}, 1'b0, rd.rd_valid);
        @(posedge rd_clk);
        #2;
        check_flag({name, " rd_valid later"}, 1'b0, rd.rd_valid);
      end
      default:
      begin
        fork
          for (int k = 0; k < e.count; k++)
          begin
            p_gap = $unsigned($random(seed)) % 4;
            repeat (p_gap) @(posedge clk);
            push_word(rand_word(), name);
          end
          for (int k = 0; k < e.count; k++)
          begin
            c_gap = $unsigned($random(seed)) % 4;
            repeat (c_gap) @(posedge rd_clk);
            pop_word(name);
          end
        join
        expect_empty(e.exp_flag, name);
      end
    endcase
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial
  begin
    seed  = 32'h18d2_ab12;
    arstn = 1'b0;
    wr    = '0;
    pop   = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    #2;
    arstn = 1'b1;
    @(posedge clk);
    #2;
    check_flag("reset empty", 1'b1, empty);
    check_flag("reset full", 1'b0, full);
    check_flag("reset rd_valid", 1'b0, rd.rd_valid);
    for (int i = 0; i < N_OPS; i++)
    begin
      apply_op(i);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/fifo_geom_pkg.sv
hdl/fifo_data_pkg.sv
hdl/gray_ptr_sync.sv
hdl/wr_ptr_ctrl.sv
hdl/rd_ptr_ctrl.sv
hdl/dual_clk_ram.sv
hdl/async_fifo_top.sv
sim/async_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: async_fifo

sources:
  # Packages first, the modules import them
  - files:
      - hdl/fifo_geom_pkg.sv
      - hdl/fifo_data_pkg.sv
  # FIFO RTL
  - files:
      - hdl/gray_ptr_sync.sv
      - hdl/wr_ptr_ctrl.sv
      - hdl/rd_ptr_ctrl.sv
      - hdl/dual_clk_ram.sv
      - hdl/async_fifo_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/async_fifo_tb.sv
